// File: project.f
rtl/cpuPkg.sv
rtl/datapathIf.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/memoryUnit.sv
rtl/programFlow.sv
rtl/srcCpu.sv
testbench/controlUnit_asserts.sv
testbench/cpuChecker.sv
testbench/cpuTb.sv

// File: rtl/aluUnit.sv
`timescale 1ns/100ps

module aluUnit
	import cpuPkg::*;
(
	input logic Clock,
	input logic Reset,
	datapathIf.datapath ctrl,
	input logic [DataWidth-1:0] busIn,
	output logic [DataWidth-1:0] zLow
);
	logic [DataWidth-1:0] y;
	logic [DataWidth-1:0] result;
	logic [4:0] shiftAmount;

	assign shiftAmount = busIn[4:0];

	// Y holds the first operand between states
	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			y <= '0;
		else if (ctrl.yIn)
			y <= busIn;
	end

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:
				result = y + busIn;
			aluSub:
				result = y - busIn;
			aluAnd:
				result = y & busIn;
			aluOr:
				result = y | busIn;
			aluShr:
				result = y >> shiftAmount; // logical
			aluShl:
				result = y << shiftAmount;
			aluIncPc:
				result = busIn + 1'b1;
			default:
				result = '0;
		endcase
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			zLow <= '0;
		else if (ctrl.zIn)
			zLow <= result;
	end

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/100ps

module controlUnit
	import cpuPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic Start,
	input opcodeT opcode,
	input logic conff,
	datapathIf.control ctrl,
	output logic loadAllowed,
	output logic Halted
);
	stateT state, nextState;

	function automatic aluOpT opToAlu(input opcodeT op);
		case (op)
			opSub: return aluSub;
			opShr: return aluShr;
			opShl: return aluShl;
			opAnd, opAndi: return aluAnd;
			opOr, opOri: return aluOr;
			default: return aluAdd; // add, addi, ldi and address sums
		endcase
	endfunction

	// first execute state per opcode
	function automatic stateT decode(input opcodeT op);
		case (op)
			opAdd, opSub, opShr, opShl, opAnd, opOr: return alu3;
			opAddi, opAndi, opOri, opLdi: return imm3;
			opLd: return ld3;
			opSt: return st3;
			opBr: return br3;
			opIn: return in3;
			opOut: return out3;
			opHalt: return halted;
			default: return nop3; // nop and anything undefined
		endcase
	endfunction

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			state <= idle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: if (Start) nextState = fetch0;
			fetch0: nextState = fetch1;
			fetch1: nextState = fetch2;
			fetch2: nextState = decode(opcode); // opcode is looked ahead from the bus
			alu3: nextState = alu4;
			alu4: nextState = alu5;
			imm3: nextState = imm4;
			imm4: nextState = imm5;
			ld3: nextState = ld4;
			ld4: nextState = ld5;
			ld5: nextState = ld6;
			ld6: nextState = ld7;
			st3: nextState = st4;
			st4: nextState = st5;
			st5: nextState = st6;
			br3: nextState = br4;
			br4: nextState = br5;
			br5: nextState = br6;
			halted: nextState = halted; // only Reset leaves
			default: nextState = fetch0; // last execute states
		endcase
	end

	always_comb begin
		ctrl.busSource = busReg;
		ctrl.gra = 1'b0;
		ctrl.grb = 1'b0;
		ctrl.grc = 1'b0;
		ctrl.rIn = 1'b0;
		ctrl.rOut = 1'b0;
		ctrl.baOut = 1'b0;
		ctrl.yIn = 1'b0;
		ctrl.zIn = 1'b0;
		ctrl.aluOp = opToAlu(opcode);
		ctrl.marIn = 1'b0;
		ctrl.mdrIn = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.pcIn = 1'b0;
		ctrl.irIn = 1'b0;
		ctrl.conIn = 1'b0;
		ctrl.outIn = 1'b0;
		case (state)
			fetch0: begin
				ctrl.busSource = busPc;
				ctrl.marIn = 1'b1;
				ctrl.aluOp = aluIncPc;
				ctrl.zIn = 1'b1;
			end
			fetch1: begin
				ctrl.busSource = busZLow;
				ctrl.pcIn = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			fetch2: begin
				ctrl.busSource = busMdr;
				ctrl.irIn = 1'b1;
			end
			alu3, imm3, ld3, st3: begin // Rb into Y
				ctrl.grb = 1'b1;
				ctrl.rOut = (state == alu3) || (state == imm3 && opcode != opLdi);
				ctrl.baOut = !ctrl.rOut; // ldi, ld, st treat R0 as zero
				ctrl.yIn = 1'b1;
			end
			alu4: begin
				ctrl.grc = 1'b1;
				ctrl.rOut = 1'b1;
				ctrl.zIn = 1'b1;
			end
			imm4, ld4, st4, br5: begin
				ctrl.busSource = busConstant;
				ctrl.zIn = 1'b1;
			end
			alu5, imm5: begin
				ctrl.busSource = busZLow;
				ctrl.gra = 1'b1;
				ctrl.rIn = 1'b1;
			end
			ld5, st5: begin
				ctrl.busSource = busZLow;
				ctrl.marIn = 1'b1;
			end
			ld6: begin
				ctrl.memRead = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			ld7: begin
				ctrl.busSource = busMdr;
				ctrl.gra = 1'b1;
				ctrl.rIn = 1'b1;
			end
			st6: begin
				ctrl.gra = 1'b1;
				ctrl.rOut = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			br3: begin
				ctrl.gra = 1'b1;
				ctrl.rOut = 1'b1;
				ctrl.conIn = 1'b1;
			end
			br4: begin
				ctrl.busSource = busPc;
				ctrl.yIn = 1'b1;
			end
			br6: begin
				ctrl.busSource = busZLow;
				ctrl.pcIn = conff; // taken only on condition
			end
			in3: begin
				ctrl.busSource = busInPort;
				ctrl.gra = 1'b1;
				ctrl.rIn = 1'b1;
			end
			out3: begin
				ctrl.gra = 1'b1;
				ctrl.rOut = 1'b1;
				ctrl.outIn = 1'b1;
			end
			default: ;
		endcase
	end

	assign loadAllowed = (state == idle);
	assign Halted = (state == halted);

endmodule

// File: rtl/cpuPkg.sv
package cpuPkg;

	localparam int DataWidth = 32;
	localparam int RegCount = 16;

	// instruction fields
	localparam int OpHi = 31;
	localparam int OpLo = 27;
	localparam int RaHi = 26;
	localparam int RaLo = 23;
	localparam int RbHi = 22;
	localparam int RbLo = 19;
	localparam int RcHi = 18;
	localparam int RcLo = 15;
	localparam int CHi = 18; // 19-bit constant
	localparam int CLo = 0;
	localparam int C2Hi = 20; // branch condition, overlaps Rb
	localparam int C2Lo = 19;

	typedef enum logic [4:0] {
		opLd   = 5'd0,
		opLdi  = 5'd1,
		opSt   = 5'd2,
		opAdd  = 5'd3,
		opSub  = 5'd4,
		opShr  = 5'd5,
		opShl  = 5'd6,
		opAnd  = 5'd9,
		opOr   = 5'd10,
		opAddi = 5'd11,
		opAndi = 5'd12,
		opOri  = 5'd13,
		opBr   = 5'd18,
		opIn   = 5'd21,
		opOut  = 5'd22,
		opNop  = 5'd25,
		opHalt = 5'd26
	} opcodeT;

	typedef enum logic [5:0] {
		idle, fetch0, fetch1, fetch2,
		alu3, alu4, alu5,
		imm3, imm4, imm5,
		ld3, ld4, ld5, ld6, ld7,
		st3, st4, st5, st6,
		br3, br4, br5, br6,
		in3, out3, nop3, halted
	} stateT;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShl,
		aluIncPc // bus + 1, Y unused
	} aluOpT;

	typedef enum logic [2:0] {
		busReg, busPc, busZLow, busMdr, busInPort, busConstant
	} busSourceT;

endpackage

// File: rtl/datapathIf.sv
`timescale 1ns/100ps

interface datapathIf
	import cpuPkg::*;
();
	busSourceT busSource;
	logic gra, grb, grc; // register select
	logic rIn, rOut, baOut;
	logic yIn, zIn;
	aluOpT aluOp;
	logic marIn, mdrIn, memRead, memWrite;
	logic pcIn, irIn, conIn;
	logic outIn;

	modport control (
		output busSource, gra, grb, grc, rIn, rOut, baOut,
		output yIn, zIn, aluOp,
		output marIn, mdrIn, memRead, memWrite,
		output pcIn, irIn, conIn, outIn
	);

	modport datapath (
		input busSource, gra, grb, grc, rIn, rOut, baOut,
		input yIn, zIn, aluOp,
		input marIn, mdrIn, memRead, memWrite,
		input pcIn, irIn, conIn, outIn
	);

endinterface

// File: rtl/memoryUnit.sv
`timescale 1ns/100ps

module memoryUnit
	import cpuPkg::*;
#(
	parameter int MemoryDepth = 512,
	parameter int AddressWidth = 9
)(
	input logic Clock,
	input logic Reset,
	datapathIf.datapath ctrl,
	input logic [DataWidth-1:0] busIn,
	input logic LoadWrite,
	input logic [AddressWidth-1:0] LoadAddress,
	input logic [DataWidth-1:0] LoadData,
	input logic loadAllowed,
	output logic [DataWidth-1:0] mdrOut
);
	logic [DataWidth-1:0] ram [MemoryDepth];
	logic [AddressWidth-1:0] mar;
	logic [DataWidth-1:0] ramData;

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			mar <= '0;
		else if (ctrl.marIn)
			mar <= busIn[AddressWidth-1:0]; // upper address bits dropped
	end

	assign ramData = ram[mar]; // asynchronous read, MDR samples it

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			mdrOut <= '0;
		else if (ctrl.mdrIn && ctrl.memRead)
			mdrOut <= ramData;
	end

	// host port only while idle
	always_ff @(posedge Clock) begin
		if (ctrl.memWrite)
			ram[mar] <= busIn;
		else if (LoadWrite && loadAllowed)
			ram[LoadAddress] <= LoadData;
	end

endmodule

// File: rtl/programFlow.sv
`timescale 1ns/100ps

module programFlow
	import cpuPkg::*;
(
	input logic Clock,
	input logic Reset,
	datapathIf.datapath ctrl,
	input logic [DataWidth-1:0] busIn,
	input logic [DataWidth-1:0] InPort,
	output logic [DataWidth-1:0] pcOut,
	output logic [DataWidth-1:0] irOut,
	output logic [DataWidth-1:0] constant,
	output logic [DataWidth-1:0] inPortOut,
	output opcodeT opcode,
	output logic conff,
	output logic [DataWidth-1:0] OutPort,
	output logic OutValid
);
	localparam int CWidth = CHi - CLo + 1;

	logic [1:0] c2;
	logic condition;

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			pcOut <= '0;
			irOut <= '0;
			inPortOut <= '0;
			OutPort <= '0;
			OutValid <= 1'b0;
			conff <= 1'b0;
		end else begin
			if (ctrl.pcIn)
				pcOut <= busIn;
			if (ctrl.irIn)
				irOut <= busIn;
			inPortOut <= InPort; // sampled every clock
			if (ctrl.outIn)
				OutPort <= busIn;
			OutValid <= ctrl.outIn; // one cycle, with the new value
			if (ctrl.conIn)
				conff <= condition;
		end
	end

	// decode straight off the bus while IR loads, so fetch2 can branch
	assign opcode = opcodeT'(ctrl.irIn ? busIn[OpHi:OpLo] : irOut[OpHi:OpLo]);

	assign constant = {{(DataWidth - CWidth){irOut[CHi]}}, irOut[CHi:CLo]};

	assign c2 = irOut[C2Hi:C2Lo];

	always_comb begin
		case (c2)
			2'd0: condition = (busIn == '0);
			2'd1: condition = (busIn != '0);
			2'd2: condition = !busIn[DataWidth-1] && (busIn != '0); // strictly positive
			default: condition = busIn[DataWidth-1];
		endcase
	end

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/100ps

module registerFile
	import cpuPkg::*;
(
	input logic Clock,
	input logic Reset,
	datapathIf.datapath ctrl,
	input logic [DataWidth-1:0] ir,
	input logic [DataWidth-1:0] busIn,
	output logic [DataWidth-1:0] regOut
);
	localparam int IndexWidth = $clog2(RegCount);

	logic [DataWidth-1:0] regs [RegCount];
	logic [IndexWidth-1:0] index;

	// field select from the IR
	always_comb begin
		index = '0;
		if (ctrl.gra)
			index = ir[RaHi:RaLo];
		else if (ctrl.grb)
			index = ir[RbHi:RbLo];
		else if (ctrl.grc)
			index = ir[RcHi:RcLo];
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < RegCount; i++)
				regs[i] <= '0;
		end else if (ctrl.rIn) begin
			regs[index] <= busIn;
		end
	end

	always_comb begin
		regOut = '0;
		if (ctrl.baOut && index == '0)
			regOut = '0; // R0 as base address reads zero
		else if (ctrl.rOut || ctrl.baOut)
			regOut = regs[index];
	end

endmodule

// File: rtl/srcCpu.sv
`timescale 1ns/100ps

module srcCpu
	import cpuPkg::*;
#(
	parameter int MemoryDepth = 512,
	localparam int AddressWidth = $clog2(MemoryDepth)
)(
	input logic Clock,
	input logic Reset,
	input logic Start,
	input logic LoadWrite,
	input logic [AddressWidth-1:0] LoadAddress,
	input logic [DataWidth-1:0] LoadData,
	input logic [DataWidth-1:0] InPort,
	output logic [DataWidth-1:0] OutPort,
	output logic OutValid,
	output logic Halted
);
	datapathIf dpIf ();

	logic [DataWidth-1:0] bus;
	logic [DataWidth-1:0] regOut, zLow, mdrOut, pcOut, irOut, constant, inPortOut;
	opcodeT opcode;
	logic conff;
	logic loadAllowed;

	controlUnit i_controlUnit (
		.Clock(Clock), .Reset(Reset), .Start(Start), .opcode(opcode), .conff(conff),
		.ctrl(dpIf.control), .loadAllowed(loadAllowed), .Halted(Halted)
	);

	registerFile i_registerFile (
		.Clock(Clock), .Reset(Reset), .ctrl(dpIf.datapath), .ir(irOut),
		.busIn(bus), .regOut(regOut)
	);

	aluUnit i_aluUnit (
		.Clock(Clock), .Reset(Reset), .ctrl(dpIf.datapath), .busIn(bus), .zLow(zLow)
	);

	memoryUnit #(.MemoryDepth(MemoryDepth), .AddressWidth(AddressWidth)) i_memoryUnit (
		.Clock(Clock), .Reset(Reset), .ctrl(dpIf.datapath), .busIn(bus),
		.LoadWrite(LoadWrite), .LoadAddress(LoadAddress), .LoadData(LoadData),
		.loadAllowed(loadAllowed), .mdrOut(mdrOut)
	);

	programFlow i_programFlow (
		.Clock(Clock), .Reset(Reset), .ctrl(dpIf.datapath), .busIn(bus), .InPort(InPort),
		.pcOut(pcOut), .irOut(irOut), .constant(constant), .inPortOut(inPortOut),
		.opcode(opcode), .conff(conff), .OutPort(OutPort), .OutValid(OutValid)
	);

	// the single shared bus
	always_comb begin
		case (dpIf.busSource)
			busPc: bus = pcOut;
			busZLow: bus = zLow;
			busMdr: bus = mdrOut;
			busInPort: bus = inPortOut;
			busConstant: bus = constant;
			default: bus = regOut; // zero unless rOut or baOut
		endcase
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run cpuTb with Verilator, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f project.f \
	&& ./obj_dir/VcpuTb > sim.log 2>&1 \
	|| echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// File: testbench/controlUnit_asserts.sv
`timescale 1ns/100ps

module controlUnit_asserts
	import cpuPkg::*;
(
	input logic Clock,
	input logic Reset,
	input stateT state,
	input logic memRead,
	input logic memWrite,
	input logic outIn
);
	int failures = 0; // failed assertions so far

	memoryExclusive: assert property (@(posedge Clock) !(memRead && memWrite))
		else begin
			$error("memRead and memWrite are high in the same cycle");
			failures++;
		end

	// OutValid is outIn one clock later
	outSingleCycle: assert property (@(posedge Clock) disable iff (Reset) outIn |=> !outIn)
		else begin
			$error("outIn high for two cycles in a row, OutValid would be too");
			failures++;
		end

	idleAfterReset: assert property (@(posedge Clock) $fell(Reset) |-> state == idle)
		else begin
			$error("control FSM is not idle when Reset is released");
			failures++;
		end

endmodule

bind controlUnit controlUnit_asserts i_controlUnitAsserts (
	.Clock(Clock), .Reset(Reset), .state(state),
	.memRead(ctrl.memRead), .memWrite(ctrl.memWrite), .outIn(ctrl.outIn)
);

// File: testbench/cpuChecker.sv
`timescale 1ns/100ps

module cpuChecker
	import cpuPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic Start,
	input logic [DataWidth-1:0] OutPort,
	input logic OutValid,
	input logic Halted,
	input logic [DataWidth-1:0] expected [4],
	input int expectedCount,
	output int errorCount
);
	int seen = 0; // OutValid pulses since reset
	int errors = 0;
	logic running = 1'b0;
	logic wasHalted = 1'b0;

	assign errorCount = errors;

	// values sampled before the edge updates them
	always @(posedge Clock) begin
		if (Reset) begin
			if (OutValid || Halted) begin
				$display("OutValid or Halted is high during reset at %0t", $time);
				errors++;
			end
			seen = 0;
			running = 1'b0;
			wasHalted = 1'b0;
		end else begin
			if (OutValid) begin
				if (!running) begin
					$display("OutValid appeared before Start at %0t", $time);
					errors++;
				end else if (Halted) begin
					$display("OutValid appeared after halt at %0t", $time);
					errors++;
				end else if (seen >= expectedCount) begin
					$display("more OutValid pulses than expected at %0t", $time);
					errors++;
				end else if (OutPort !== expected[seen]) begin
					$display("CHECK FAILED at %0t: OutPort %h, expected %h",
						$time, OutPort, expected[seen]);
					errors++;
				end
				seen++;
			end
			if (Start)
				running = 1'b1;
			if (Halted && !wasHalted && seen != expectedCount) begin
				$display("halted after %0d OutValid pulses, %0d were expected", seen,
					expectedCount);
				errors++;
			end
			if (wasHalted && !Halted) begin
				$display("Halted dropped without a reset at %0t", $time);
				errors++;
			end
			wasHalted = Halted;
		end
	end

endmodule

// File: testbench/cpuTb.sv
`timescale 1ns/100ps

module cpuTb
	import cpuPkg::*;
();
	localparam int MemoryDepth = 512;
	localparam int AddressWidth = $clog2(MemoryDepth);
	localparam int MaxTests = 16;
	localparam int DataAddress = 100; // word preloaded over the host port
	localparam logic [18:0] TakenMark = 19'h0a5;
	localparam logic [18:0] NotTakenMark = 19'h05a;

	logic Clock, Reset, Start, LoadWrite;
	logic [AddressWidth-1:0] LoadAddress;
	logic [DataWidth-1:0] LoadData, InPort, OutPort;
	logic OutValid, Halted;
	logic [DataWidth-1:0] expected [4];
	int expectedCount;
	int errorCount;

	// stimulus table, one row per test
	logic [DataWidth-1:0] progTable [MaxTests][8];
	int progLength [MaxTests];
	logic [DataWidth-1:0] inTable [MaxTests];
	logic [DataWidth-1:0] preloadTable [MaxTests];
	bit preloadEnable [MaxTests];
	logic [DataWidth-1:0] expTable [MaxTests][4];
	int expLength [MaxTests];
	int testCount = 0;
	int seed = 32'hd8f4;

	srcCpu #(.MemoryDepth(MemoryDepth)) i_srcCpu (
		.Clock(Clock), .Reset(Reset), .Start(Start), .LoadWrite(LoadWrite),
		.LoadAddress(LoadAddress), .LoadData(LoadData), .InPort(InPort),
		.OutPort(OutPort), .OutValid(OutValid), .Halted(Halted)
	);

	cpuChecker i_cpuChecker (
		.Clock(Clock), .Reset(Reset), .Start(Start), .OutPort(OutPort), .OutValid(OutValid),
		.Halted(Halted), .expected(expected), .expectedCount(expectedCount),
		.errorCount(errorCount)
	);

	always #20 Clock = ~Clock;

	function automatic logic [31:0] encodeReg(input logic [4:0] op, input int ra, rb, rc);
		return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
	endfunction

	function automatic logic [31:0] encodeImm(input logic [4:0] op, input int ra, rb,
			input logic [18:0] c);
		return {op, 4'(ra), 4'(rb), c};
	endfunction

	function automatic logic [31:0] encodeBranch(input int ra, input logic [1:0] c2,
			input logic [18:0] c);
		return {opBr, 4'(ra), 2'b00, c2, c};
	endfunction

	function automatic logic [31:0] signExtend(input logic [18:0] c);
		return {{13{c[18]}}, c};
	endfunction

	function automatic bit branchTaken(input logic [1:0] c2, input logic [31:0] v);
		case (c2)
			2'd0: return v == 0;
			2'd1: return v != 0;
			2'd2: return !v[31] && v != 0; // positive means above zero
			default: return v[31];
		endcase
	endfunction

	task automatic addWord(input logic [31:0] word);
		progTable[testCount][progLength[testCount]] = word;
		progLength[testCount]++;
	endtask

	task automatic expectOut(input logic [31:0] value);
		expTable[testCount][expLength[testCount]] = value;
		expLength[testCount]++;
	endtask

	// every program ends in halt
	task automatic closeTest(input logic [31:0] inValue, input bit preload,
			input logic [31:0] preloadValue);
		addWord(encodeReg(opHalt, 0, 0, 0));
		inTable[testCount] = inValue;
		preloadEnable[testCount] = preload;
		preloadTable[testCount] = preloadValue;
		testCount++;
	endtask

	task automatic buildTable();
		logic [18:0] ca, cb, cc, cs, cv;
		logic [31:0] a, b, portValue, preloadValue;
		logic [1:0] cond;
		ca = 19'($random(seed));
		cb = 19'($random(seed));
		cc = 19'($random(seed));
		cs = 19'($random(seed)); // only its low five bits set the shift
		a = signExtend(ca);
		b = signExtend(cb);
		for (int i = 0; i < 3; i++) begin // add/sub, and/or, shl/shr
			addWord(encodeImm(opLdi, 1, 0, ca));
			addWord(encodeImm(opLdi, 2, 0, (i == 2) ? cs : cb));
			addWord(encodeReg((i == 0) ? opAdd : (i == 1) ? opAnd : opShl, 3, 1, 2));
			addWord(encodeReg(opOut, 3, 0, 0));
			addWord(encodeReg((i == 0) ? opSub : (i == 1) ? opOr : opShr, 4, 1, 2));
			addWord(encodeReg(opOut, 4, 0, 0));
			expectOut((i == 0) ? a + b : (i == 1) ? (a & b) : a << cs[4:0]);
			expectOut((i == 0) ? a - b : (i == 1) ? (a | b) : a >> cs[4:0]);
			closeTest('0, 1'b0, '0);
		end
		addWord(encodeImm(opLdi, 1, 0, ca));
		addWord(encodeImm(opAddi, 2, 1, cc));
		addWord(encodeReg(opOut, 2, 0, 0));
		addWord(encodeImm(opAndi, 3, 1, cc));
		addWord(encodeReg(opOut, 3, 0, 0));
		addWord(encodeImm(opOri, 4, 1, cc));
		addWord(encodeReg(opOut, 4, 0, 0));
		expectOut(a + signExtend(cc));
		expectOut(a & signExtend(cc));
		expectOut(a | signExtend(cc));
		closeTest('0, 1'b0, '0);
		preloadValue = $random(seed);
		addWord(encodeImm(opLdi, 1, 0, ca));
		addWord(encodeImm(opLdi, 2, 0, 19'd20));
		addWord(encodeImm(opSt, 1, 2, 19'd5)); // address 25
		addWord(encodeImm(opLd, 3, 2, 19'd5));
		addWord(encodeReg(opOut, 3, 0, 0));
		addWord(encodeImm(opLd, 4, 0, 19'(DataAddress)));
		addWord(encodeReg(opOut, 4, 0, 0));
		expectOut(a);
		expectOut(preloadValue);
		closeTest('0, 1'b1, preloadValue);
		for (int i = 0; i < 8; i++) begin // two operands per condition
			cond = 2'(i / 2);
			cv = 19'($random(seed));
			if (i % 2 == 1) begin
				cv[18] = 1'b0;
				cv[0] = 1'b1;
			end else if (cond < 2)
				cv = '0;
			else
				cv[18] = 1'b1;
			addWord(encodeImm(opLdi, 2, 0, TakenMark));
			addWord(encodeImm(opLdi, 1, 0, cv));
			addWord(encodeBranch(1, cond, 19'd1)); // skips the next word
			addWord(encodeImm(opLdi, 2, 0, NotTakenMark));
			addWord(encodeReg(opOut, 2, 0, 0));
			expectOut(branchTaken(cond, signExtend(cv)) ? signExtend(TakenMark) :
				signExtend(NotTakenMark));
			closeTest('0, 1'b0, '0);
		end
		portValue = $random(seed);
		addWord(encodeReg(opIn, 1, 0, 0));
		addWord(encodeReg(opOut, 1, 0, 0));
		addWord(encodeReg(opNop, 1, 0, 0));
		addWord({5'd31, 27'd0}); // undefined opcode
		addWord(encodeReg(opOut, 1, 0, 0));
		expectOut(portValue);
		expectOut(portValue);
		closeTest(portValue, 1'b0, '0);
		// host writes while halted went to this word and must be lost
		addWord(encodeImm(opLdi, 0, 0, cb | 19'd1)); // R0 set but reads zero as a base
		addWord(encodeImm(opLd, 1, 0, 19'(DataAddress)));
		addWord(encodeReg(opOut, 1, 0, 0));
		addWord(encodeImm(opLdi, 2, 0, ca));
		addWord(encodeReg(opOut, 2, 0, 0));
		expectOut(preloadValue);
		expectOut(a);
		closeTest('0, 1'b0, '0);
	endtask

	task automatic loadWord(input int address, input logic [31:0] word);
		LoadWrite = 1'b1;
		LoadAddress = AddressWidth'(address);
		LoadData = word;
		@(negedge Clock);
		LoadWrite = 1'b0;
	endtask

	initial begin
		int failedTests;
		int ranTests;
		int errorsBefore;
		int cycles;
		bit timedOut;
		Clock = 1'b0;
		Reset = 1'b1;
		Start = 1'b0;
		LoadWrite = 1'b0;
		LoadAddress = '0;
		LoadData = '0;
		InPort = '0;
		expectedCount = 0;
		for (int k = 0; k < 4; k++)
			expected[k] = '0;
		failedTests = 0;
		ranTests = 0;
		timedOut = 1'b0;
		buildTable();
		for (int t = 0; t < testCount && !timedOut; t++) begin
			@(negedge Clock);
			Reset = 1'b1;
			errorsBefore = errorCount;
			InPort = inTable[t];
			expectedCount = expLength[t];
			for (int k = 0; k < 4; k++)
				expected[k] = expTable[t][k];
			repeat (8) @(negedge Clock);
			Reset = 1'b0;
			for (int w = 0; w < progLength[t]; w++)
				loadWord(w, progTable[t][w]);
			if (preloadEnable[t])
				loadWord(DataAddress, preloadTable[t]);
			Start = 1'b1;
			@(negedge Clock);
			Start = 1'b0;
			cycles = 0;
			while (!Halted && cycles < 2000) begin
				@(negedge Clock);
				cycles++;
			end
			ranTests++;
			if (!Halted) begin
				$display("test %0d: Halted never rose within 2000 cycles", t);
				failedTests++;
				timedOut = 1'b1;
			end else begin
				loadWord(DataAddress, 32'hbad0bad0); // FSM is not idle, so dropped
				repeat (4) @(negedge Clock); // Halted must hold, no OutValid
				if (errorCount == errorsBefore) begin
					$display("test %0d: ok, %0d outputs", t, expLength[t]);
				end else begin
					$display("test %0d: failed, %0d errors", t, errorCount - errorsBefore);
					failedTests++;
				end
			end
		end
		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			ranTests, failedTests, errorCount,
			i_srcCpu.i_controlUnit.i_controlUnitAsserts.failures);
		if (failedTests == 0 && errorCount == 0 && !timedOut
				&& i_srcCpu.i_controlUnit.i_controlUnitAsserts.failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
